/* hw/sqrt_bound_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srt_bound_defines.svh"

module sqrt_bound_capture (
	input  wire                    cpuclk,
	input  wire                    arst_n,
	input  wire                    bound_req,
	input  wire                    first_round,
	input  wire                    secd_round,
	input  wire                    secd_sign,
	input  wire  [`SRT_SEL_W-1:0]  bound_sel,
	output logic                   req_vld,
	output srt_bound_pkg::bound_req_t req
);

	logic [`SRT_ROW_W-1:0] sel_row;
	logic                  sel_legal;

	// Select code to table row
	always_comb
	begin
		sel_legal = 1'b1;
		case (bound_sel)
			`SRT_SEL_ROW0: sel_row = 3'd0;
			`SRT_SEL_ROW1: sel_row = 3'd1;
			`SRT_SEL_ROW2: sel_row = 3'd2;
			`SRT_SEL_ROW3: sel_row = 3'd3;
			`SRT_SEL_ROW4: sel_row = 3'd4;
			default:
			begin
				sel_row   = `SRT_ROW_BAD;
				sel_legal = 1'b0;
			end
		endcase
	end

	// Request register, sampled on the strobe only
	always_ff @(posedge cpuclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			req_vld <= 1'b0;
			req     <= '0;
		end
		else
		begin
			req_vld <= bound_req;
			if (bound_req)
			begin
				req.first_round <= first_round;
				req.secd_round  <= secd_round;
				req.secd_sign   <= secd_sign;
				// First round ignores the select, park it on row 0
				req.row         <= secd_round ? sel_row : 3'd0;
			end
		end
	end

	// Only the first two rounds are handled here
	a_one_round: assert property (
		@(posedge cpuclk) disable iff (!arst_n)
		bound_req |-> (first_round ^ secd_round)
	) else $error("bound request without exactly one round flag");

	// Second round must land on a table row
	a_sel_legal: assert property (
		@(posedge cpuclk) disable iff (!arst_n)
		(bound_req && secd_round) |-> sel_legal
	) else $error("second-round bound select 0x%0h not in table", bound_sel);

endmodule

`default_nettype wire

/* hw/sqrt_bound_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srt_bound_defines.svh"

module sqrt_bound_table (
	input  wire                        cpuclk,
	input  wire                        arst_n,
	input  wire                        req_vld,
	input  wire srt_bound_pkg::bound_req_t req,
	output logic                       bound_vld,
	output srt_bound_pkg::bound_set_t  bounds
);

	// First-round bounds do not depend on the select
	// 2, 16, 53, 95, 160, 240, 335, 450, 570
	localparam srt_bound_pkg::bound_set_t first_set = {
		12'h23a, 12'h1c2, 12'h14f, 12'h0f0, 12'h0a0,
		12'h05f, 12'h035, 12'h010, 12'h002
	};

	srt_bound_pkg::bound_set_t p2_set;
	srt_bound_pkg::bound_set_t m2_set;
	srt_bound_pkg::bound_set_t secd_set;
	srt_bound_pkg::bound_set_t sel_set;

	// Plus-two table with bound 9 leading each row
	always_comb
	begin
		case (req.row)
			3'd0: p2_set = {12'h245, 12'h1fd, 12'h1b6, 12'h170, 12'h12b,
			                12'h0e7, 12'h0a4, 12'h062, 12'h021};
			3'd1: p2_set = {12'h2cd, 12'h275, 12'h21e, 12'h1c8, 12'h173,
			                12'h11f, 12'h0cc, 12'h07a, 12'h029};
			3'd2: p2_set = {12'h355, 12'h2ed, 12'h286, 12'h220, 12'h1bb,
			                12'h157, 12'h0f4, 12'h092, 12'h031};
			3'd3: p2_set = {12'h3dd, 12'h365, 12'h2ee, 12'h278, 12'h203,
			                12'h18f, 12'h11c, 12'h0aa, 12'h039};
			3'd4: p2_set = {12'h465, 12'h3dd, 12'h356, 12'h2d0, 12'h24b,
			                12'h1c7, 12'h144, 12'h0c2, 12'h041};
			default: p2_set = '0;
		endcase
	end

	// Minus-two table in the same row order
	always_comb
	begin
		case (req.row)
			3'd0: m2_set = {12'h1fc, 12'h1c4, 12'h18b, 12'h151, 12'h116,
			                12'h0da, 12'h09d, 12'h05f, 12'h020};
			3'd1: m2_set = {12'h284, 12'h23c, 12'h1f3, 12'h1a9, 12'h15e,
			                12'h112, 12'h0c5, 12'h077, 12'h028};
			3'd2: m2_set = {12'h30c, 12'h2b4, 12'h25b, 12'h201, 12'h1a6,
			                12'h14a, 12'h0ed, 12'h08f, 12'h030};
			3'd3: m2_set = {12'h394, 12'h32c, 12'h2c3, 12'h259, 12'h1ee,
			                12'h182, 12'h115, 12'h0a7, 12'h038};
			3'd4: m2_set = {12'h41c, 12'h3a4, 12'h32b, 12'h2b1, 12'h236,
			                12'h1ba, 12'h13d, 12'h0bf, 12'h040};
			default: m2_set = '0;
		endcase
	end

	// Negative second-round root digit uses the minus-two row
	assign secd_set = req.secd_sign ? m2_set : p2_set;

	// Round flags are one-hot so first_round alone picks the set
	assign sel_set = req.first_round ? first_set : secd_set;

	// Result register holds between requests
	always_ff @(posedge cpuclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bound_vld <= 1'b0;
			bounds    <= '0;
		end
		else
		begin
			bound_vld <= req_vld;
			if (req_vld)
			begin
				bounds <= sel_set;
			end
		end
	end

	// An out-of-range row means a bad select got through
	a_row_range: assert property (
		@(posedge cpuclk) disable iff (!arst_n)
		req_vld |-> (req.row < `SRT_ROW_NUM)
	) else $error("table row %0d out of range", req.row);

endmodule

`default_nettype wire

/* hw/sqrt_bound_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srt_bound_defines.svh"

module sqrt_bound_top (
	input  wire                        cpuclk,
	input  wire                        arst_n,
	input  wire                        bound_req,
	input  wire                        first_round,
	input  wire                        secd_round,
	input  wire                        secd_sign,
	input  wire  [`SRT_SEL_W-1:0]      bound_sel,
	output logic                       bound_vld,
	output srt_bound_pkg::bound_set_t  bounds
);

	// Captured request on its way to the tables
	logic                      req_vld;
	srt_bound_pkg::bound_req_t req;

	sqrt_bound_capture u_capture (
		.cpuclk      (cpuclk),
		.arst_n      (arst_n),
		.bound_req   (bound_req),
		.first_round (first_round),
		.secd_round  (secd_round),
		.secd_sign   (secd_sign),
		.bound_sel   (bound_sel),
		.req_vld     (req_vld),
		.req         (req)
	);

	// Bounds appear two edges after the strobe is sampled
	sqrt_bound_table u_table (
		.cpuclk    (cpuclk),
		.arst_n    (arst_n),
		.req_vld   (req_vld),
		.req       (req),
		.bound_vld (bound_vld),
		.bounds    (bounds)
	);

endmodule

`default_nettype wire

/* hw/srt_bound_pkg.sv */
`default_nettype none

`include "srt_bound_defines.svh"

package srt_bound_pkg;

	// One request after capture
	// row is only meaningful in the second round
	typedef struct packed {
		logic                  first_round;
		logic                  secd_round;
		logic                  secd_sign;
		logic [`SRT_ROW_W-1:0] row;
	} bound_req_t;

	// Full set of digit bounds
	// Element 1 is the lowest boundary, element 9 the highest
	typedef logic [`SRT_BOUND_NUM:1][`SRT_BOUND_W-1:0] bound_set_t;

endpackage

`default_nettype wire

/* include/srt_bound_defines.svh */
`ifndef SRT_BOUND_DEFINES_SVH
`define SRT_BOUND_DEFINES_SVH

// Width of one digit bound
`define SRT_BOUND_W 12

// Bounds per set, one for each digit boundary
`define SRT_BOUND_NUM 9

// Bound select from the partial remainder estimate
`define SRT_SEL_W 7

// Row index into the second-round tables
`define SRT_ROW_W 3

// Rows in each second-round table
`define SRT_ROW_NUM 5

// Legal second-round select codes, in table row order
`define SRT_SEL_ROW0 7'h40
`define SRT_SEL_ROW1 7'h50
`define SRT_SEL_ROW2 7'h60
`define SRT_SEL_ROW3 7'h70
`define SRT_SEL_ROW4 7'h00

// Row code given to a select that is not in the table
`define SRT_ROW_BAD 3'd7

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the bound selection testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_sqrt_bound -f src.f -o tb_sqrt_bound

# A failing run exits non-zero, so the log search gives the verdict
./obj_dir/tb_sqrt_bound > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qF '*** FAILED ***' "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -qF '*** PASSED ***' "$LOG"; then
	echo "Simulation ended without a verdict"
	exit 1
fi
echo "Simulation finished cleanly"

/* src.f */
+incdir+include
hw/srt_bound_pkg.sv
hw/sqrt_bound_capture.sv
hw/sqrt_bound_table.sv
hw/sqrt_bound_top.sv
verif/tb_sqrt_bound.sv

/* include/sqrt_bound_ref.svh */
`ifndef SQRT_BOUND_REF_SVH
`define SQRT_BOUND_REF_SVH

// Reference model of the bound selection, included inside the testbench module

// Table row of a legal second-round select, -1 for any other code
function automatic int ref_row(input logic [`SRT_SEL_W-1:0] sel);
	case (sel)
		`SRT_SEL_ROW0: return 0;
		`SRT_SEL_ROW1: return 1;
		`SRT_SEL_ROW2: return 2;
		`SRT_SEL_ROW3: return 3;
		`SRT_SEL_ROW4: return 4;
		default:       return -1;
	endcase
endfunction

// Fixed first-round bounds, bound 1 to bound 9
function automatic logic [`SRT_BOUND_W-1:0] ref_first_bound(input int k);
	case (k)
		1:       return 12'd2;
		2:       return 12'd16;
		3:       return 12'd53;
		4:       return 12'd95;
		5:       return 12'd160;
		6:       return 12'd240;
		7:       return 12'd335;
		8:       return 12'd450;
		default: return 12'd570;
	endcase
endfunction

// Row r starts near 0x20 + 8r and steps by about 0x40 + 16r per bound
// Plus-two step grows by one each bound, minus-two step shrinks by one
function automatic logic [`SRT_BOUND_W-1:0] ref_secd_bound(input int row, input int k,
	input logic sign);
	int base;
	int step;
	int tri_sum;
	int val;
	base    = 32 + 8 * row;
	step    = 64 + 16 * row;
	tri_sum = (k - 1) * k / 2;
	if (sign)
		val = base + (k - 1) * step - tri_sum;
	else
		val = base + 1 + (k - 1) * step + tri_sum;
	return val[`SRT_BOUND_W-1:0];
endfunction

// Expected bound set for one request
function automatic srt_bound_pkg::bound_set_t ref_bounds(input logic first, input logic sign,
	input logic [`SRT_SEL_W-1:0] sel);
	srt_bound_pkg::bound_set_t set;
	int row;
	row = ref_row(sel);
	set = '0;
	for (int k = 1; k <= `SRT_BOUND_NUM; k++)
	begin
		if (first)
			set[k] = ref_first_bound(k);
		else
			set[k] = ref_secd_bound(row, k, sign);
	end
	return set;
endfunction

`endif

/* verif/tb_sqrt_bound.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srt_bound_defines.svh"

module tb_sqrt_bound;

	localparam int SEED        = 79092;
	localparam int RESET_CYC   = 16;
	localparam int NUM_REQ     = 2000;
	localparam int CYCLE_LIMIT = RESET_CYC + NUM_REQ * 2 + 100;

	logic                      cpuclk;
	logic                      arst_n;
	logic                      bound_req;
	logic                      first_round;
	logic                      secd_round;
	logic                      secd_sign;
	logic [`SRT_SEL_W-1:0]     bound_sel;
	logic                      bound_vld;
	srt_bound_pkg::bound_set_t bounds;

	// Expected sets and the cycle each one is due
	srt_bound_pkg::bound_set_t exp_q[$];
	int                        due_q[$];
	srt_bound_pkg::bound_set_t last_bounds;
	srt_bound_pkg::bound_set_t exp_set;
	logic                      exp_vld;
	logic [31:0]               rnd;
	int                        cyc;
	int                        n_sent;
	int                        run_len;

	`include "sqrt_bound_ref.svh"

	sqrt_bound_top u_dut (
		.cpuclk      (cpuclk),
		.arst_n      (arst_n),
		.bound_req   (bound_req),
		.first_round (first_round),
		.secd_round  (secd_round),
		.secd_sign   (secd_sign),
		.bound_sel   (bound_sel),
		.bound_vld   (bound_vld),
		.bounds      (bounds)
	);

	initial
	begin
		cpuclk = 1'b0;
		forever #10 cpuclk = ~cpuclk;
	end

	task automatic fail_run;
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_vld(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERROR: bound_vld got 0x%0h expected 0x%0h at cycle %0d", got, exp, cyc);
			fail_run();
		end
	endtask

	task automatic check_bounds(input srt_bound_pkg::bound_set_t got,
		input srt_bound_pkg::bound_set_t exp);
		for (int i = 1; i <= `SRT_BOUND_NUM; i++)
		begin
			if (got[i] !== exp[i])
			begin
				$display("ERROR: bounds[%0d] got 0x%03h expected 0x%03h at cycle %0d",
					i, got[i], exp[i], cyc);
				fail_run();
			end
		end
	endtask

	function automatic logic [`SRT_SEL_W-1:0] sel_of_row(input int row);
		case (row)
			0:       return `SRT_SEL_ROW0;
			1:       return `SRT_SEL_ROW1;
			2:       return `SRT_SEL_ROW2;
			3:       return `SRT_SEL_ROW3;
			default: return `SRT_SEL_ROW4;
		endcase
	endfunction

	task automatic next_cycle;
		@(posedge cpuclk);
		#2;
	endtask

	// Strobe low with junk on the other inputs
	task automatic drive_idle;
		logic [31:0] r;
		r           = $urandom;
		bound_req   = 1'b0;
		first_round = r[0];
		secd_round  = r[1];
		secd_sign   = r[2];
		bound_sel   = r[`SRT_SEL_W+2:3];
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			next_cycle();
			drive_idle();
		end
	endtask

	task automatic drive_req(input logic first, input logic sign,
		input logic [`SRT_SEL_W-1:0] sel);
		bound_req   = 1'b1;
		first_round = first;
		secd_round  = !first;
		secd_sign   = sign;
		bound_sel   = sel;
		exp_q.push_back(ref_bounds(first, sign, sel));
		// Result due two edges after the drive cycle
		due_q.push_back(cyc + 2);
		n_sent = n_sent + 1;
	endtask

	task automatic drive_random_req;
		logic [31:0]           r;
		logic [`SRT_SEL_W-1:0] sel;
		int                    row;
		r   = $urandom;
		row = $urandom % 5;
		// About one request in four is first-round
		if (r[1:0] == 2'b00)
			sel = r[`SRT_SEL_W+7:8];
		else
			sel = sel_of_row(row);
		drive_req(r[1:0] == 2'b00, r[2], sel);
	endtask

	// Cycle count and run limit
	always @(posedge cpuclk)
	begin
		cyc = cyc + 1;
		if (cyc >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles with results still missing", cyc);
			fail_run();
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge cpuclk)
	begin
		exp_vld = (due_q.size() != 0) && (due_q[0] == cyc);
		check_vld(bound_vld, exp_vld);
		if (bound_vld)
		begin
			exp_set = exp_q.pop_front();
			due_q.delete(0);
			check_bounds(bounds, exp_set);
			last_bounds = exp_set;
		end
		else
			check_bounds(bounds, last_bounds);
	end

	initial
	begin
		void'($urandom(SEED));
		arst_n      = 1'b1;
		bound_req   = 1'b0;
		first_round = 1'b0;
		secd_round  = 1'b0;
		secd_sign   = 1'b0;
		bound_sel   = '0;
		last_bounds = '0;
		cyc         = 0;
		n_sent      = 0;
		#1 arst_n = 1'b0;
		repeat (RESET_CYC) @(posedge cpuclk);
		#2 arst_n = 1'b1;
		idle_cycles(10);

		// First round ignores select and sign
		repeat (3)
		begin
			next_cycle();
			rnd = $urandom;
			drive_req(1'b1, rnd[0], rnd[`SRT_SEL_W:1]);
			idle_cycles(2);
		end

		// Every plus-two row and then every minus-two row
		for (int s = 0; s < 2; s++)
		begin
			for (int r = 0; r < 5; r++)
			begin
				next_cycle();
				drive_req(1'b0, s[0], sel_of_row(r));
				idle_cycles(2);
			end
		end

		// Back-to-back runs with short gaps
		while (n_sent < NUM_REQ)
		begin
			run_len = 1 + int'($urandom % 16);
			for (int j = 0; j < run_len && n_sent < NUM_REQ; j++)
			begin
				next_cycle();
				drive_random_req();
			end
			idle_cycles(int'($urandom % 4));
		end

		while (due_q.size() != 0)
			idle_cycles(1);
		idle_cycles(8);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
